// File: verilog/qrd_pkg.sv
`default_nettype none

package qrd_pkg;

    // ==============================
    // Host line and addressing
    // ==============================
    localparam int LINE_BITS        = 512;
    localparam int LINE_OFFSET_BITS = 6;
    localparam int BYTE_ADDR_BITS   = 48;
    localparam int LINE_ADDR_BITS   = BYTE_ADDR_BITS - LINE_OFFSET_BITS;

    // Lane geometry
    localparam int NUM_LANES  = 3;
    localparam int VEC_LEN    = 2;
    localparam int FLOAT_BITS = 32;
    localparam int ROW_BITS   = 3;
    localparam int COL_BITS   = 2;

    // ==============================
    // Register map
    // ==============================
    localparam int CSR_ADDR_BITS = 3;
    localparam int CSR_DATA_BITS = 64;

    localparam logic [CSR_ADDR_BITS-1:0] CSR_IN_ADDR    = 3'd0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_START      = 3'd1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_OUT_ADDR   = 3'd2;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_STATUS     = 3'd3;
    // Word 4 is a hole in the map
    localparam logic [CSR_ADDR_BITS-1:0] CSR_LANE_CLEAR = 3'd5;

    // ==============================
    // Lane payloads
    // ==============================
    typedef logic [VEC_LEN-1:0][FLOAT_BITS-1:0] vec_t;

    // Write fields sit above the read fields
    typedef struct packed {
        logic                wr_en;
        logic [ROW_BITS-1:0] wr_row;
        logic [COL_BITS-1:0] wr_col;
        vec_t                wr_vec;
        logic                rd_en;
        logic [ROW_BITS-1:0] rd_row;
        logic [COL_BITS-1:0] rd_col;
    } lane_cmd_t;

    typedef struct packed {
        logic valid;
        vec_t vec;
    } lane_reply_t;

    // Slot widths within a host line, lane 0 at the bottom
    localparam int LANE_CMD_BITS   = $bits(lane_cmd_t);
    localparam int LANE_REPLY_BITS = $bits(lane_reply_t);

endpackage

`default_nettype wire

// File: verilog/qrd_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module qrd_csr_regs (
    input  logic                               clk,
    input  logic                               is_reset_signal_written,
    input  logic                               csr_cyc,
    input  logic                               csr_stb,
    input  logic                               csr_we,
    input  logic [qrd_pkg::CSR_ADDR_BITS-1:0]  csr_adr,
    input  logic [qrd_pkg::CSR_DATA_BITS-1:0]  csr_dat_w,
    input  logic                               busy,
    input  logic                               done,
    input  logic [7:0]                         job_count,
    output logic                               csr_ack,
    output logic [qrd_pkg::CSR_DATA_BITS-1:0]  csr_dat_r,
    output logic [qrd_pkg::LINE_ADDR_BITS-1:0] in_line_addr,
    output logic [qrd_pkg::LINE_ADDR_BITS-1:0] out_line_addr,
    output logic                               start,
    output logic                               lane_clear
);
    import qrd_pkg::*;

    logic                     access;
    logic                     wr_access;
    logic [CSR_DATA_BITS-1:0] rd_data;

    // Byte address from the CPU to line address
    function automatic logic [LINE_ADDR_BITS-1:0] to_line_addr(
        input logic [CSR_DATA_BITS-1:0] data
    );
        logic [BYTE_ADDR_BITS-1:0] byte_addr;
        byte_addr = data[BYTE_ADDR_BITS-1:0];
        return byte_addr[BYTE_ADDR_BITS-1:LINE_OFFSET_BITS];
    endfunction

    function automatic logic [CSR_DATA_BITS-1:0] to_csr_word(
        input logic [LINE_ADDR_BITS-1:0] line_addr
    );
        logic [BYTE_ADDR_BITS-1:0] byte_addr;
        byte_addr = {line_addr, {LINE_OFFSET_BITS{1'b0}}};
        return CSR_DATA_BITS'(byte_addr);
    endfunction

    // New access only when no ack is pending
    assign access    = csr_cyc && csr_stb && !csr_ack;
    assign wr_access = access && csr_we;

    always_comb begin
        case (csr_adr)
            CSR_IN_ADDR:  rd_data = to_csr_word(in_line_addr);
            CSR_OUT_ADDR: rd_data = to_csr_word(out_line_addr);
            CSR_STATUS:   rd_data = CSR_DATA_BITS'({job_count, 6'b0, done, busy});
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (is_reset_signal_written) begin
            csr_ack    <= 1'b0;
            start      <= 1'b0;
            lane_clear <= 1'b0;
        end else begin
            csr_ack    <= access;
            start      <= wr_access && (csr_adr == CSR_START);
            // Stores must not be wiped under a running job
            lane_clear <= wr_access && (csr_adr == CSR_LANE_CLEAR) && !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_access && (csr_adr == CSR_IN_ADDR)) begin
            in_line_addr <= to_line_addr(csr_dat_w);
        end
        if (wr_access && (csr_adr == CSR_OUT_ADDR)) begin
            out_line_addr <= to_line_addr(csr_dat_w);
        end
        if (access && !csr_we) begin
            csr_dat_r <= rd_data;
        end
    end

    // Master keeps stb up through the ack cycle
    ack_needs_stb: assert property (@(posedge clk) disable iff (is_reset_signal_written)
        csr_ack |-> csr_stb);

endmodule

`default_nettype wire

// File: verilog/qrd_job_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module qrd_job_ctrl #(
    parameter int NUM_LANES = qrd_pkg::NUM_LANES
) (
    input  logic                                  clk,
    input  logic                                  is_reset_signal_written,
    input  logic                                  start,
    input  logic [qrd_pkg::LINE_ADDR_BITS-1:0]    in_line_addr,
    input  logic [qrd_pkg::LINE_ADDR_BITS-1:0]    out_line_addr,
    input  logic                                  mem_ack,
    input  logic [qrd_pkg::LINE_BITS-1:0]         mem_dat_r,
    input  qrd_pkg::lane_reply_t [NUM_LANES-1:0]  lane_reply,
    output logic                                  mem_cyc,
    output logic                                  mem_stb,
    output logic                                  mem_we,
    output logic [qrd_pkg::LINE_ADDR_BITS-1:0]    mem_adr,
    output logic [qrd_pkg::LINE_BITS-1:0]         mem_dat_w,
    output qrd_pkg::lane_cmd_t [NUM_LANES-1:0]    lane_cmd,
    output logic                                  lane_cmd_valid,
    output logic                                  busy,
    output logic                                  done,
    output logic [7:0]                            job_count
);
    import qrd_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_APPLY,
        ST_COLLECT,
        ST_STORE
    } state_t;

    state_t               state;
    logic                 bus_phase;
    logic [LINE_BITS-1:0] result_line;

    // Bus requests live only in the fetch and store states
    assign bus_phase = (state == ST_FETCH) || (state == ST_STORE);
    assign mem_cyc   = bus_phase;
    assign mem_stb   = bus_phase;
    assign mem_we    = (state == ST_STORE);
    assign busy      = (state != ST_IDLE);

    // Reply k at k * 65, upper bits zero
    always_comb begin
        result_line = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            result_line[k*LANE_REPLY_BITS +: LANE_REPLY_BITS] = lane_reply[k];
        end
    end

    // ==============================
    // Job sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (is_reset_signal_written) begin
            state          <= ST_IDLE;
            lane_cmd_valid <= 1'b0;
            done           <= 1'b0;
            job_count      <= '0;
        end else begin
            lane_cmd_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_FETCH;
                        done  <= 1'b0;
                    end
                end
                ST_FETCH: begin
                    if (mem_ack) begin
                        state          <= ST_APPLY;
                        lane_cmd_valid <= 1'b1;
                    end
                end
                // Lane stores register their replies here
                ST_APPLY: begin
                    state <= ST_COLLECT;
                end
                ST_COLLECT: begin
                    state <= ST_STORE;
                end
                ST_STORE: begin
                    if (mem_ack) begin
                        state     <= ST_IDLE;
                        done      <= 1'b1;
                        job_count <= job_count + 8'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Addresses, command slices and result line
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && start) begin
            mem_adr <= in_line_addr;
        end
        if ((state == ST_FETCH) && mem_ack) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                lane_cmd[k] <= mem_dat_r[k*LANE_CMD_BITS +: LANE_CMD_BITS];
            end
        end
        if (state == ST_COLLECT) begin
            mem_adr   <= out_line_addr;
            mem_dat_w <= result_line;
        end
    end

    stb_implies_cyc: assert property (@(posedge clk) disable iff (is_reset_signal_written)
        mem_stb |-> mem_cyc);

    // A request waiting for ack holds still
    req_held_until_ack: assert property (@(posedge clk) disable iff (is_reset_signal_written)
        (mem_stb && !mem_ack) |=> (mem_stb && $stable(mem_adr) && $stable(mem_we)));

endmodule

`default_nettype wire

// File: verilog/qrd_lane_store.sv
`timescale 1ns/1ps
`default_nettype none

module qrd_lane_store #(
    parameter int ROW_BITS = qrd_pkg::ROW_BITS,
    parameter int COL_BITS = qrd_pkg::COL_BITS
) (
    input  logic                 clk,
    input  logic                 is_reset_signal_written,
    input  logic                 lane_clear,
    input  logic                 cmd_valid,
    input  qrd_pkg::lane_cmd_t   cmd,
    output qrd_pkg::lane_reply_t reply
);
    import qrd_pkg::*;

    localparam int ROWS = 1 << ROW_BITS;
    localparam int COLS = 1 << COL_BITS;

    vec_t                      store [ROWS][COLS];
    logic [ROWS-1:0][COLS-1:0] entry_valid;
    logic [ROW_BITS-1:0]       wr_row;
    logic [COL_BITS-1:0]       wr_col;
    logic [ROW_BITS-1:0]       rd_row;
    logic [COL_BITS-1:0]       rd_col;
    logic                      do_write;
    logic                      do_read;
    logic                      rd_valid_q;
    vec_t                      rd_vec_q;

    assign wr_row   = ROW_BITS'(cmd.wr_row);
    assign wr_col   = COL_BITS'(cmd.wr_col);
    assign rd_row   = ROW_BITS'(cmd.rd_row);
    assign rd_col   = COL_BITS'(cmd.rd_col);
    assign do_write = cmd_valid && cmd.wr_en;
    assign do_read  = cmd_valid && cmd.rd_en;

    // Entry valid bits, all dropped on a clear
    always_ff @(posedge clk) begin
        if (is_reset_signal_written) begin
            entry_valid <= '0;
            rd_valid_q  <= 1'b0;
        end else begin
            rd_valid_q <= do_read;
            if (lane_clear) begin
                entry_valid <= '0;
            end else if (do_write) begin
                entry_valid[wr_row][wr_col] <= 1'b1;
            end
        end
    end

    // Read sees the old entry when it hits the one being written
    always_ff @(posedge clk) begin
        if (do_write) begin
            store[wr_row][wr_col] <= cmd.wr_vec;
        end
        if (cmd_valid) begin
            rd_vec_q <= (do_read && entry_valid[rd_row][rd_col]) ? store[rd_row][rd_col] : '0;
        end
    end

    assign reply = '{valid: rd_valid_q, vec: rd_vec_q};

    // Clear is blocked while a job runs
    no_cmd_during_clear: assert property (@(posedge clk) disable iff (is_reset_signal_written)
        !(cmd_valid && lane_clear));

endmodule

`default_nettype wire

// File: verilog/qrd_top.sv
`timescale 1ns/1ps
`default_nettype none

module qrd_top #(
    parameter int NUM_LANES = qrd_pkg::NUM_LANES,
    parameter int ROW_BITS  = qrd_pkg::ROW_BITS,
    parameter int COL_BITS  = qrd_pkg::COL_BITS
) (
    input  logic                               clk,
    input  logic                               is_reset_signal_written,
    input  logic                               csr_cyc,
    input  logic                               csr_stb,
    input  logic                               csr_we,
    input  logic [qrd_pkg::CSR_ADDR_BITS-1:0]  csr_adr,
    input  logic [qrd_pkg::CSR_DATA_BITS-1:0]  csr_dat_w,
    input  logic                               mem_ack,
    input  logic [qrd_pkg::LINE_BITS-1:0]      mem_dat_r,
    output logic                               csr_ack,
    output logic [qrd_pkg::CSR_DATA_BITS-1:0]  csr_dat_r,
    output logic                               mem_cyc,
    output logic                               mem_stb,
    output logic                               mem_we,
    output logic [qrd_pkg::LINE_ADDR_BITS-1:0] mem_adr,
    output logic [qrd_pkg::LINE_BITS-1:0]      mem_dat_w
);
    import qrd_pkg::*;

    logic [LINE_ADDR_BITS-1:0]   in_line_addr;
    logic [LINE_ADDR_BITS-1:0]   out_line_addr;
    logic                        start;
    logic                        lane_clear;
    logic                        busy;
    logic                        done;
    logic [7:0]                  job_count;
    logic                        lane_cmd_valid;
    lane_cmd_t   [NUM_LANES-1:0] lane_cmd;
    lane_reply_t [NUM_LANES-1:0] lane_reply;

    qrd_csr_regs i_csr_regs (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .csr_cyc                 (csr_cyc),
        .csr_stb                 (csr_stb),
        .csr_we                  (csr_we),
        .csr_adr                 (csr_adr),
        .csr_dat_w               (csr_dat_w),
        .busy                    (busy),
        .done                    (done),
        .job_count               (job_count),
        .csr_ack                 (csr_ack),
        .csr_dat_r               (csr_dat_r),
        .in_line_addr            (in_line_addr),
        .out_line_addr           (out_line_addr),
        .start                   (start),
        .lane_clear              (lane_clear)
    );

    qrd_job_ctrl #(
        .NUM_LANES (NUM_LANES)
    ) i_job_ctrl (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .start                   (start),
        .in_line_addr            (in_line_addr),
        .out_line_addr           (out_line_addr),
        .mem_ack                 (mem_ack),
        .mem_dat_r               (mem_dat_r),
        .lane_reply              (lane_reply),
        .mem_cyc                 (mem_cyc),
        .mem_stb                 (mem_stb),
        .mem_we                  (mem_we),
        .mem_adr                 (mem_adr),
        .mem_dat_w               (mem_dat_w),
        .lane_cmd                (lane_cmd),
        .lane_cmd_valid          (lane_cmd_valid),
        .busy                    (busy),
        .done                    (done),
        .job_count               (job_count)
    );

    // One vector store per lane
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        qrd_lane_store #(
            .ROW_BITS (ROW_BITS),
            .COL_BITS (COL_BITS)
        ) i_lane_store (
            .clk                     (clk),
            .is_reset_signal_written (is_reset_signal_written),
            .lane_clear              (lane_clear),
            .cmd_valid               (lane_cmd_valid),
            .cmd                     (lane_cmd[k]),
            .reply                   (lane_reply[k])
        );
    end

endmodule

`default_nettype wire

// File: verification/wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model (
    input  logic                               clk,
    input  logic                               is_reset_signal_written,
    input  logic                               mem_cyc,
    input  logic                               mem_stb,
    input  logic                               mem_we,
    input  logic [qrd_pkg::LINE_ADDR_BITS-1:0] mem_adr,
    input  logic [qrd_pkg::LINE_BITS-1:0]      mem_dat_w,
    input  logic [1:0]                         ack_delay,
    input  logic                               load_en,
    input  logic [qrd_pkg::LINE_ADDR_BITS-1:0] load_adr,
    input  logic [qrd_pkg::LINE_BITS-1:0]      load_dat,
    output logic                               mem_ack,
    output logic [qrd_pkg::LINE_BITS-1:0]      mem_dat_r,
    output logic [qrd_pkg::LINE_ADDR_BITS-1:0] last_wr_adr,
    output logic [qrd_pkg::LINE_BITS-1:0]      last_wr_dat
);
    import qrd_pkg::*;

    logic [LINE_BITS-1:0] lines [logic [LINE_ADDR_BITS-1:0]];
    logic [1:0]           wait_cnt;

    always @(posedge clk) begin
        if (is_reset_signal_written) begin
            mem_ack     <= 1'b0;
            wait_cnt    <= '0;
            mem_dat_r   <= '0;
            last_wr_adr <= '0;
            last_wr_dat <= '0;
        end else begin
            mem_ack <= 1'b0;
            // Ack after 0 to 3 wait cycles, one cycle wide
            if (mem_cyc && mem_stb && !mem_ack) begin
                if (wait_cnt >= ack_delay) begin
                    mem_ack  <= 1'b1;
                    wait_cnt <= '0;
                    if (mem_we) begin
                        lines[mem_adr] = mem_dat_w;
                        last_wr_adr <= mem_adr;
                        last_wr_dat <= mem_dat_w;
                    end else if (lines.exists(mem_adr)) begin
                        mem_dat_r <= lines[mem_adr];
                    end else begin
                        mem_dat_r <= '0;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 2'd1;
                end
            end
            if (load_en) begin
                lines[load_adr] = load_dat;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/qrd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module qrd_tb;
    import qrd_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 20 * 40 + RESET_CYCLES;
    // Slot widths in a host line
    localparam int CMD_SLOT     = 76;
    localparam int REPLY_SLOT   = 65;
    localparam int ROWS         = 1 << ROW_BITS;
    localparam int COLS         = 1 << COL_BITS;

    logic                      clk = 1'b0;
    logic                      is_reset_signal_written;
    logic                      csr_cyc;
    logic                      csr_stb;
    logic                      csr_we;
    logic [CSR_ADDR_BITS-1:0]  csr_adr;
    logic [CSR_DATA_BITS-1:0]  csr_dat_w;
    logic                      csr_ack;
    logic [CSR_DATA_BITS-1:0]  csr_dat_r;
    logic                      mem_cyc;
    logic                      mem_stb;
    logic                      mem_we;
    logic [LINE_ADDR_BITS-1:0] mem_adr;
    logic [LINE_BITS-1:0]      mem_dat_w;
    logic                      mem_ack;
    logic [LINE_BITS-1:0]      mem_dat_r;
    logic [1:0]                ack_delay = 2'd0;
    logic                      load_en;
    logic [LINE_ADDR_BITS-1:0] load_adr;
    logic [LINE_BITS-1:0]      load_dat;
    logic [LINE_ADDR_BITS-1:0] last_wr_adr;
    logic [LINE_BITS-1:0]      last_wr_dat;

    logic [31:0]         lfsr_state = 32'hb2e7_11f2;
    int                  cycle_count = 0;
    int                  check_count = 0;
    int                  error_count = 0;
    int                  jobs_done = 0;
    vec_t                model [NUM_LANES][ROWS][COLS];
    bit                  written [NUM_LANES][ROWS][COLS];
    logic [ROW_BITS-1:0] saved_row [NUM_LANES];
    logic [COL_BITS-1:0] saved_col [NUM_LANES];

    qrd_top i_qrd_top (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .csr_cyc                 (csr_cyc),
        .csr_stb                 (csr_stb),
        .csr_we                  (csr_we),
        .csr_adr                 (csr_adr),
        .csr_dat_w               (csr_dat_w),
        .mem_ack                 (mem_ack),
        .mem_dat_r               (mem_dat_r),
        .csr_ack                 (csr_ack),
        .csr_dat_r               (csr_dat_r),
        .mem_cyc                 (mem_cyc),
        .mem_stb                 (mem_stb),
        .mem_we                  (mem_we),
        .mem_adr                 (mem_adr),
        .mem_dat_w               (mem_dat_w)
    );

    wb_mem_model i_mem (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .mem_cyc                 (mem_cyc),
        .mem_stb                 (mem_stb),
        .mem_we                  (mem_we),
        .mem_adr                 (mem_adr),
        .mem_dat_w               (mem_dat_w),
        .ack_delay               (ack_delay),
        .load_en                 (load_en),
        .load_adr                (load_adr),
        .load_dat                (load_dat),
        .mem_ack                 (mem_ack),
        .mem_dat_r               (mem_dat_r),
        .last_wr_adr             (last_wr_adr),
        .last_wr_dat             (last_wr_dat)
    );

    always #50 clk = ~clk;

    // ==============================
    // Random source and checking
    // ==============================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < VEC_LEN; i++) begin
            v[i] = rand_bits(FLOAT_BITS);
        end
        return v;
    endfunction

    // Memory model ack delay redrawn every cycle
    always @(posedge clk) begin
        ack_delay <= 2'(rand_bits(2));
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
                     MAX_CYCLES, error_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input logic [LINE_BITS-1:0] got,
                         input logic [LINE_BITS-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // ==============================
    // Bus tasks
    // ==============================
    task automatic csr_write(input logic [CSR_ADDR_BITS-1:0] adr,
                             input logic [CSR_DATA_BITS-1:0] data);
        csr_cyc   = 1'b1;
        csr_stb   = 1'b1;
        csr_we    = 1'b1;
        csr_adr   = adr;
        csr_dat_w = data;
        @(negedge clk);
        while (!csr_ack) begin
            @(negedge clk);
        end
        // Stb stays up through the ack cycle
        @(negedge clk);
        csr_cyc = 1'b0;
        csr_stb = 1'b0;
        csr_we  = 1'b0;
    endtask

    task automatic csr_read(input logic [CSR_ADDR_BITS-1:0] adr,
                            output logic [CSR_DATA_BITS-1:0] data);
        csr_cyc = 1'b1;
        csr_stb = 1'b1;
        csr_we  = 1'b0;
        csr_adr = adr;
        @(negedge clk);
        while (!csr_ack) begin
            @(negedge clk);
        end
        data = csr_dat_r;
        @(negedge clk);
        csr_cyc = 1'b0;
        csr_stb = 1'b0;
    endtask

    task automatic load_line(input logic [LINE_ADDR_BITS-1:0] adr,
                             input logic [LINE_BITS-1:0] data);
        load_en  = 1'b1;
        load_adr = adr;
        load_dat = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_job(input bit extra_start, output logic [CSR_DATA_BITS-1:0] status);
        csr_write(CSR_START, 64'd1);
        if (extra_start) begin
            // Arrives while the first job is running
            csr_write(CSR_START, 64'd1);
        end
        csr_read(CSR_STATUS, status);
        while (!status[1]) begin
            csr_read(CSR_STATUS, status);
        end
    endtask

    function automatic lane_cmd_t make_cmd(
        input logic wr_en, input logic [ROW_BITS-1:0] wr_row,
        input logic [COL_BITS-1:0] wr_col, input vec_t wr_vec,
        input logic rd_en, input logic [ROW_BITS-1:0] rd_row,
        input logic [COL_BITS-1:0] rd_col
    );
        lane_cmd_t c;
        c.wr_en  = wr_en;
        c.wr_row = wr_row;
        c.wr_col = wr_col;
        c.wr_vec = wr_vec;
        c.rd_en  = rd_en;
        c.rd_row = rd_row;
        c.rd_col = rd_col;
        return c;
    endfunction

    task automatic apply_commands(input lane_cmd_t [NUM_LANES-1:0] cmds,
                                  input bit extra_start);
        logic [LINE_BITS-1:0]     cmd_line;
        logic [LINE_BITS-1:0]     exp_line;
        logic [CSR_DATA_BITS-1:0] in_byte;
        logic [CSR_DATA_BITS-1:0] out_byte;
        logic [CSR_DATA_BITS-1:0] status;
        lane_reply_t              rep;
        cmd_line = '0;
        exp_line = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            cmd_line[k*CMD_SLOT +: CMD_SLOT] = cmds[k];
            // Reply sees the entry before this command's write
            rep.valid = cmds[k].rd_en;
            rep.vec   = '0;
            if (cmds[k].rd_en && written[k][cmds[k].rd_row][cmds[k].rd_col]) begin
                rep.vec = model[k][cmds[k].rd_row][cmds[k].rd_col];
            end
            exp_line[k*REPLY_SLOT +: REPLY_SLOT] = rep;
            if (cmds[k].wr_en) begin
                model[k][cmds[k].wr_row][cmds[k].wr_col]   = cmds[k].wr_vec;
                written[k][cmds[k].wr_row][cmds[k].wr_col] = 1'b1;
            end
        end
        // Junk in the low offset bits
        in_byte  = 64'h0010_0000 + (64'(jobs_done) << 6) + 64'h2b;
        out_byte = 64'h0020_0000 + (64'(jobs_done) << 6) + 64'h11;
        load_line(in_byte[BYTE_ADDR_BITS-1:LINE_OFFSET_BITS], cmd_line);
        csr_write(CSR_IN_ADDR, in_byte);
        csr_write(CSR_OUT_ADDR, out_byte);
        run_job(extra_start, status);
        jobs_done++;
        check("csr_dat_r status", LINE_BITS'(status), LINE_BITS'((64'(jobs_done) << 8) | 64'h2));
        check("mem_adr write back", LINE_BITS'(last_wr_adr),
              LINE_BITS'(out_byte[BYTE_ADDR_BITS-1:LINE_OFFSET_BITS]));
        check("mem_dat_w result line", last_wr_dat, exp_line);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic regs_after_reset();
        logic [CSR_DATA_BITS-1:0] data;
        // Both buses idle out of reset
        check("csr_ack", LINE_BITS'(csr_ack), '0);
        check("mem_cyc", LINE_BITS'(mem_cyc), '0);
        check("mem_stb", LINE_BITS'(mem_stb), '0);
        csr_read(CSR_STATUS, data);
        check("csr_dat_r status", LINE_BITS'(data), '0);
        csr_write(CSR_IN_ADDR, 64'h0000_abcd_1234_56ff);
        csr_read(CSR_IN_ADDR, data);
        check("csr_dat_r in_addr", LINE_BITS'(data), LINE_BITS'(64'h0000_abcd_1234_56c0));
        csr_write(CSR_OUT_ADDR, 64'h0000_0123_4567_89a5);
        csr_read(CSR_OUT_ADDR, data);
        check("csr_dat_r out_addr", LINE_BITS'(data), LINE_BITS'(64'h0000_0123_4567_8980));
        csr_read(3'd4, data);
        check("csr_dat_r unused", LINE_BITS'(data), '0);
    endtask

    task automatic write_read_back();
        lane_cmd_t [NUM_LANES-1:0] cmds;
        // Rows 0 to 3 only so rows 4 to 7 stay unwritten
        for (int k = 0; k < NUM_LANES; k++) begin
            saved_row[k] = ROW_BITS'(rand_bits(2));
            saved_col[k] = COL_BITS'(rand_bits(COL_BITS));
            cmds[k] = make_cmd(1'b1, saved_row[k], saved_col[k], rand_vec(), 1'b0, '0, '0);
        end
        apply_commands(cmds, 1'b0);
        for (int k = 0; k < NUM_LANES; k++) begin
            cmds[k] = make_cmd(1'b0, '0, '0, '0, 1'b1, saved_row[k], saved_col[k]);
        end
        apply_commands(cmds, 1'b0);
    endtask

    task automatic read_before_write();
        lane_cmd_t [NUM_LANES-1:0] cmds;
        for (int k = 0; k < NUM_LANES; k++) begin
            cmds[k] = make_cmd(1'b1, saved_row[k], saved_col[k], rand_vec(),
                               1'b1, saved_row[k], saved_col[k]);
        end
        apply_commands(cmds, 1'b0);
        for (int k = 0; k < NUM_LANES; k++) begin
            cmds[k] = make_cmd(1'b0, '0, '0, '0, 1'b1, saved_row[k], saved_col[k]);
        end
        apply_commands(cmds, 1'b0);
        for (int k = 0; k < NUM_LANES; k++) begin
            cmds[k] = make_cmd(1'b0, '0, '0, '0, 1'b1, ROW_BITS'(4 + rand_bits(2)),
                               COL_BITS'(rand_bits(COL_BITS)));
        end
        apply_commands(cmds, 1'b0);
    endtask

    task automatic clear_all_lanes();
        lane_cmd_t [NUM_LANES-1:0] cmds;
        csr_write(CSR_LANE_CLEAR, 64'd1);
        for (int k = 0; k < NUM_LANES; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    written[k][r][c] = 1'b0;
                end
            end
            cmds[k] = make_cmd(1'b0, '0, '0, '0, 1'b1, saved_row[k], saved_col[k]);
        end
        apply_commands(cmds, 1'b0);
    endtask

    task automatic status_across_jobs();
        lane_cmd_t [NUM_LANES-1:0] cmds;
        for (int k = 0; k < NUM_LANES; k++) begin
            cmds[k] = make_cmd(1'b1, saved_row[k], saved_col[k], rand_vec(),
                               1'b1, saved_row[k], saved_col[k]);
        end
        apply_commands(cmds, 1'b1);
        for (int k = 0; k < NUM_LANES; k++) begin
            cmds[k] = make_cmd(1'b0, '0, '0, '0, 1'b1, saved_row[k], saved_col[k]);
        end
        apply_commands(cmds, 1'b0);
    endtask

    initial begin
        is_reset_signal_written = 1'b1;
        csr_cyc   = 1'b0;
        csr_stb   = 1'b0;
        csr_we    = 1'b0;
        csr_adr   = '0;
        csr_dat_w = '0;
        load_en   = 1'b0;
        load_adr  = '0;
        load_dat  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        is_reset_signal_written = 1'b0;
        regs_after_reset();
        write_read_back();
        read_before_write();
        clear_all_lanes();
        status_across_jobs();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/qrd_pkg.sv
verilog/qrd_csr_regs.sv
verilog/qrd_job_ctrl.sv
verilog/qrd_lane_store.sv
verilog/qrd_top.sv
verification/wb_mem_model.sv
verification/qrd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the qrd testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module qrd_tb --Mdir "$BUILD_DIR" -o qrd_sim -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/qrd_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
